// ==== src/core_cfg.svh ====
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////

// Register and ALU word
`define CORE_DATA_W   32
// Instruction word and opcode field
`define CORE_INSTR_W  16
`define CORE_OP_W     6

// Instruction memory depth is 2**CORE_IMEM_AW
`define CORE_IMEM_AW  8
// 32 architectural registers
`define CORE_RF_AW    5

//////////////////////////////
// Network addressing
//////////////////////////////

`define CORE_NET_ID_W 10
`define CORE_NET_ID   10'd1

// First fetch address out of reset
`define CORE_RESET_PC 8'd0

`endif

// ==== src/core_pkg.sv ====
`include "core_cfg.svh"

package core_pkg;

    // Opcode field, top bits of every instruction
    typedef enum logic [`CORE_OP_W-1:0] {
        OP_NOP   = 6'h00,
        OP_ADD   = 6'h01,
        OP_SUB   = 6'h02,
        OP_AND   = 6'h03,
        OP_OR    = 6'h04,
        OP_MOV   = 6'h05,
        OP_ADDI  = 6'h06,
        OP_BEQZ  = 6'h07,
        OP_BNEQZ = 6'h08,
        OP_JALR  = 6'h09,
        OP_DONE  = 6'h0A
    } opcode_e;

    // Packet command carried on the network port
    typedef enum logic [1:0] {
        NET_PC    = 2'd0,
        NET_INSTR = 2'd1,
        NET_REG   = 2'd2,
        NET_NONE  = 2'd3
    } net_op_e;

    // Core run state
    typedef enum logic {
        IDLE = 1'b0,
        RUN  = 1'b1
    } state_e;

    // Register form: rd op= rs
    typedef struct packed {
        opcode_e                 opcode;
        logic [`CORE_RF_AW-1:0]  rd;
        logic [`CORE_RF_AW-1:0]  rs;
    } instr_reg_s;

    // Immediate form, low field is a signed offset or constant
    typedef struct packed {
        opcode_e                       opcode;
        logic [`CORE_RF_AW-1:0]        rd;
        logic signed [`CORE_RF_AW-1:0] imm;
    } instr_imm_s;

    // One 16-bit word, two views of the low field
    typedef union packed {
        instr_reg_s r;
        instr_imm_s i;
    } instr_u;

endpackage

// ==== src/net_ctrl.sv ====
`timescale 1ns/100ps
`include "core_cfg.svh"

module net_ctrl (
    input  logic                       clk,
    input  logic                       n_reset,
    input  logic                       pkt_valid_i,
    input  logic [`CORE_NET_ID_W-1:0]  pkt_id_i,
    input  core_pkg::net_op_e          pkt_op_i,
    input  logic [`CORE_IMEM_AW-1:0]   pkt_addr_i,
    input  logic [`CORE_DATA_W-1:0]    pkt_data_i,
    input  logic                       done_i,
    output logic                       imem_we_o,
    output logic [`CORE_IMEM_AW-1:0]   imem_waddr_o,
    output core_pkg::instr_u           imem_wdata_o,
    output logic                       net_rf_we_o,
    output logic [`CORE_RF_AW-1:0]     net_rf_waddr_o,
    output logic [`CORE_DATA_W-1:0]    net_rf_wdata_o,
    output logic                       start_o,
    output logic [`CORE_IMEM_AW-1:0]   start_pc_o,
    output logic                       running_o,
    output logic                       exception_o
);

    core_pkg::state_e state_r;
    logic             pkt_hit;
    logic             idle;
    logic             pc_cmd;

    // Packet counts only when valid and addressed to this core
    assign pkt_hit = pkt_valid_i && (pkt_id_i == `CORE_NET_ID);
    assign idle    = (state_r == core_pkg::IDLE);
    assign pc_cmd  = pkt_hit && (pkt_op_i == core_pkg::NET_PC);

    // Loads are accepted only while IDLE, dropped while running
    assign imem_we_o    = pkt_hit && idle && (pkt_op_i == core_pkg::NET_INSTR);
    assign imem_waddr_o = pkt_addr_i;
    assign imem_wdata_o = pkt_data_i[`CORE_INSTR_W-1:0];

    // Register address must fit the register file, upper address bits zero
    assign net_rf_we_o    = pkt_hit && idle && (pkt_op_i == core_pkg::NET_REG)
                            && (pkt_addr_i[`CORE_IMEM_AW-1:`CORE_RF_AW] == '0);
    assign net_rf_waddr_o = pkt_addr_i[`CORE_RF_AW-1:0];
    assign net_rf_wdata_o = pkt_data_i;

    // PC write while IDLE starts the program at the packet address
    assign start_o    = pc_cmd && idle;
    assign start_pc_o = pkt_addr_i;

    assign running_o = (state_r == core_pkg::RUN);

    //////////////////////////////
    // Run state and exception
    //////////////////////////////
    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            state_r     <= core_pkg::IDLE;
            exception_o <= 1'b0;
        end
        else
        begin
            if (start_o)
                state_r <= core_pkg::RUN;
            // DONE committed, back to IDLE
            else if (done_i && running_o)
                state_r <= core_pkg::IDLE;
            // Sticky until reset
            if (pc_cmd && running_o)
                exception_o <= 1'b1;
        end
    end

endmodule

// ==== src/fetch_unit.sv ====
`timescale 1ns/100ps
`include "core_cfg.svh"

module fetch_unit (
    input  logic                      clk,
    input  logic                      n_reset,
    input  logic                      running_i,
    input  logic                      start_i,
    input  logic [`CORE_IMEM_AW-1:0]  start_pc_i,
    input  logic                      redirect_i,
    input  logic [`CORE_IMEM_AW-1:0]  redirect_pc_i,
    input  logic                      imem_we_i,
    input  logic [`CORE_IMEM_AW-1:0]  imem_waddr_i,
    input  core_pkg::instr_u          imem_wdata_i,
    output logic                      f_valid_o,
    output core_pkg::instr_u          f_instr_o,
    output logic [`CORE_IMEM_AW-1:0]  f_pc_o
);

    logic [`CORE_IMEM_AW-1:0] pc_r;
    logic [`CORE_IMEM_AW-1:0] pc_n;

    // Instruction memory, written only by the network
    core_pkg::instr_u imem [2**`CORE_IMEM_AW];

    // Next PC priority is start, redirect, then sequential
    always_comb
    begin
        pc_n = pc_r;
        if (start_i)
            pc_n = start_pc_i;
        else if (redirect_i)
            pc_n = redirect_pc_i;
        // PC holds while IDLE
        else if (running_i)
            pc_n = pc_r + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!n_reset)
            pc_r <= `CORE_RESET_PC;
        else
            pc_r <= pc_n;
    end

    //////////////////////////////
    // Instruction memory
    //////////////////////////////

    // Synchronous read of the current PC, one cycle of latency
    always_ff @(posedge clk)
    begin
        if (imem_we_i)
            imem[imem_waddr_i] <= imem_wdata_i;
        f_instr_o <= imem[pc_r];
        f_pc_o    <= pc_r;
    end

    // Word read during a redirect is on the wrong path
    always_ff @(posedge clk)
    begin
        if (!n_reset)
            f_valid_o <= 1'b0;
        else
            f_valid_o <= running_i && !redirect_i && !start_i;
    end

endmodule

// ==== src/decode_stage.sv ====
`timescale 1ns/100ps
`include "core_cfg.svh"

module decode_stage (
    input  logic                      clk,
    input  logic                      n_reset,
    input  logic                      f_valid_i,
    input  core_pkg::instr_u          f_instr_i,
    input  logic [`CORE_IMEM_AW-1:0]  f_pc_i,
    input  logic                      flush_i,
    input  logic                      rf_we_i,
    input  logic [`CORE_RF_AW-1:0]    rf_waddr_i,
    input  logic [`CORE_DATA_W-1:0]   rf_wdata_i,
    output logic                      d_valid_o,
    output core_pkg::instr_u          d_instr_o,
    output logic [`CORE_IMEM_AW-1:0]  d_pc_o,
    output logic [`CORE_DATA_W-1:0]   d_rs_val_o,
    output logic [`CORE_DATA_W-1:0]   d_rd_val_o,
    output logic                      d_writes_rf_o
);

    logic [`CORE_DATA_W-1:0] rf [2**`CORE_RF_AW];
    logic [`CORE_DATA_W-1:0] rs_val;
    logic [`CORE_DATA_W-1:0] rd_val;
    logic                    writes_rf;

    //////////////////////////////
    // Register file
    //////////////////////////////

    // r0 is hardwired to zero
    // A write in this cycle is seen by the read, no extra forward path needed
    function automatic logic [`CORE_DATA_W-1:0] rf_read(input logic [`CORE_RF_AW-1:0] addr);
        if (addr == '0)
            return '0;
        if (rf_we_i && (rf_waddr_i == addr))
            return rf_wdata_i;
        return rf[addr];
    endfunction

    always_ff @(posedge clk)
    begin
        if (rf_we_i)
            rf[rf_waddr_i] <= rf_wdata_i;
    end

    // Both fields read through the register view
    // For immediate forms the rs read is don't care
    always_comb
    begin
        rs_val = rf_read(f_instr_i.r.rs);
        rd_val = rf_read(f_instr_i.r.rd);
    end

    //////////////////////////////
    // Control decode
    //////////////////////////////
    always_comb
    begin
        case (f_instr_i.r.opcode)
            core_pkg::OP_ADD,
            core_pkg::OP_SUB,
            core_pkg::OP_AND,
            core_pkg::OP_OR,
            core_pkg::OP_MOV,
            core_pkg::OP_ADDI,
            core_pkg::OP_JALR:
                writes_rf = 1'b1;
            // Branches, NOP and DONE leave the register file alone
            default:
                writes_rf = 1'b0;
        endcase
    end

    // Decode to execute register
    always_ff @(posedge clk)
    begin
        if (!n_reset)
            d_valid_o <= 1'b0;
        else
            d_valid_o <= f_valid_i && !flush_i;
    end

    always_ff @(posedge clk)
    begin
        d_instr_o     <= f_instr_i;
        d_pc_o        <= f_pc_i;
        d_rs_val_o    <= rs_val;
        d_rd_val_o    <= rd_val;
        d_writes_rf_o <= writes_rf;
    end

endmodule

// ==== src/execute_stage.sv ====
`timescale 1ns/100ps
`include "core_cfg.svh"

module execute_stage (
    input  logic                      clk,
    input  logic                      n_reset,
    input  logic                      d_valid_i,
    input  core_pkg::instr_u          d_instr_i,
    input  logic [`CORE_IMEM_AW-1:0]  d_pc_i,
    input  logic [`CORE_DATA_W-1:0]   d_rs_val_i,
    input  logic [`CORE_DATA_W-1:0]   d_rd_val_i,
    input  logic                      d_writes_rf_i,
    input  logic                      fwd_we_i,
    input  logic [`CORE_RF_AW-1:0]    fwd_addr_i,
    input  logic [`CORE_DATA_W-1:0]   fwd_data_i,
    output logic                      redirect_o,
    output logic [`CORE_IMEM_AW-1:0]  redirect_pc_o,
    output logic                      x_valid_o,
    output logic                      x_we_o,
    output logic [`CORE_RF_AW-1:0]    x_waddr_o,
    output logic [`CORE_DATA_W-1:0]   x_wdata_o,
    output logic                      x_done_o
);

    core_pkg::opcode_e               op;
    logic [`CORE_DATA_W-1:0]         rs_val;
    logic [`CORE_DATA_W-1:0]         rd_val;
    logic signed [`CORE_DATA_W-1:0]  imm_ext;
    logic [`CORE_IMEM_AW-1:0]        ret_pc;
    logic [`CORE_IMEM_AW-1:0]        br_target;
    logic [`CORE_DATA_W-1:0]         alu_res;
    logic                            taken;
    logic                            jump;

    assign op = d_instr_i.r.opcode;

    // Older instruction sitting in result, forward its write
    assign rs_val = (fwd_we_i && (fwd_addr_i != '0) && (fwd_addr_i == d_instr_i.r.rs))
                    ? fwd_data_i : d_rs_val_i;
    assign rd_val = (fwd_we_i && (fwd_addr_i != '0) && (fwd_addr_i == d_instr_i.r.rd))
                    ? fwd_data_i : d_rd_val_i;

    // Sign extension of the immediate view
    assign imm_ext   = d_instr_i.i.imm;
    assign br_target = d_pc_i + imm_ext[`CORE_IMEM_AW-1:0];
    assign ret_pc    = d_pc_i + 1'b1;

    //////////////////////////////
    // ALU and branch compare
    //////////////////////////////
    always_comb
    begin
        alu_res = rd_val;
        taken   = 1'b0;
        jump    = 1'b0;
        case (op)
            core_pkg::OP_ADD:   alu_res = rd_val + rs_val;
            core_pkg::OP_SUB:   alu_res = rd_val - rs_val;
            core_pkg::OP_AND:   alu_res = rd_val & rs_val;
            core_pkg::OP_OR:    alu_res = rd_val | rs_val;
            core_pkg::OP_MOV:   alu_res = rs_val;
            core_pkg::OP_ADDI:  alu_res = rd_val + imm_ext;
            // Link value is the return address
            core_pkg::OP_JALR:
            begin
                alu_res = {{(`CORE_DATA_W-`CORE_IMEM_AW){1'b0}}, ret_pc};
                jump    = 1'b1;
            end
            // Branches test rd against zero
            core_pkg::OP_BEQZ:  taken = (rd_val == '0);
            core_pkg::OP_BNEQZ: taken = (rd_val != '0);
            default:            alu_res = rd_val;
        endcase
    end

    // Resolved here, so two younger slots are on the wrong path
    assign redirect_o    = d_valid_i && (taken || jump);
    assign redirect_pc_o = jump ? rs_val[`CORE_IMEM_AW-1:0] : br_target;

    // Execute to result register
    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            x_valid_o <= 1'b0;
            x_we_o    <= 1'b0;
            x_done_o  <= 1'b0;
        end
        else
        begin
            x_valid_o <= d_valid_i;
            x_we_o    <= d_valid_i && d_writes_rf_i;
            x_done_o  <= d_valid_i && (op == core_pkg::OP_DONE);
        end
    end

    always_ff @(posedge clk)
    begin
        x_waddr_o <= d_instr_i.r.rd;
        x_wdata_o <= alu_res;
    end

endmodule

// ==== src/result_stage.sv ====
`timescale 1ns/100ps
`include "core_cfg.svh"

module result_stage (
    input  logic                     clk,
    input  logic                     n_reset,
    input  logic                     x_valid_i,
    input  logic                     x_we_i,
    input  logic [`CORE_RF_AW-1:0]   x_waddr_i,
    input  logic [`CORE_DATA_W-1:0]  x_wdata_i,
    input  logic                     x_done_i,
    input  logic                     net_rf_we_i,
    input  logic [`CORE_RF_AW-1:0]   net_rf_waddr_i,
    input  logic [`CORE_DATA_W-1:0]  net_rf_wdata_i,
    output logic                     rf_we_o,
    output logic [`CORE_RF_AW-1:0]   rf_waddr_o,
    output logic [`CORE_DATA_W-1:0]  rf_wdata_o,
    output logic                     done_o
);

    // Set once DONE commits, blocks the shadow behind it
    logic stopped_r;
    logic pipe_we;
    logic net_we;

    // Fetch stops when running falls, so the shadow after DONE is one
    // unbroken run of valid slots, and the first bubble ends it
    always_ff @(posedge clk)
    begin
        if (!n_reset)
            stopped_r <= 1'b0;
        else if (done_o)
            stopped_r <= 1'b1;
        else if (!x_valid_i)
            stopped_r <= 1'b0;
    end

    assign done_o = x_valid_i && x_done_i && !stopped_r;

    // r0 writes are dropped at the port
    assign pipe_we = x_valid_i && x_we_i && !stopped_r && (x_waddr_i != '0);
    assign net_we  = net_rf_we_i && (net_rf_waddr_i != '0);

    // Network writes only arrive while IDLE, no overlap with the pipeline
    assign rf_we_o    = net_we || pipe_we;
    assign rf_waddr_o = net_rf_we_i ? net_rf_waddr_i : x_waddr_i;
    assign rf_wdata_o = net_rf_we_i ? net_rf_wdata_i : x_wdata_i;

endmodule

// ==== src/net_core.sv ====
`timescale 1ns/100ps
`include "core_cfg.svh"

module net_core (
    input  logic                      clk,
    input  logic                      n_reset,
    input  logic                      pkt_valid_i,
    input  logic [`CORE_NET_ID_W-1:0] pkt_id_i,
    input  core_pkg::net_op_e         pkt_op_i,
    input  logic [`CORE_IMEM_AW-1:0]  pkt_addr_i,
    input  logic [`CORE_DATA_W-1:0]   pkt_data_i,
    output logic                      running_o,
    output logic                      exception_o,
    output logic                      trace_we_o,
    output logic [`CORE_RF_AW-1:0]    trace_addr_o,
    output logic [`CORE_DATA_W-1:0]   trace_data_o
);

    // Network loads and control
    logic                     imem_we;
    logic [`CORE_IMEM_AW-1:0] imem_waddr;
    core_pkg::instr_u         imem_wdata;
    logic                     net_rf_we;
    logic [`CORE_RF_AW-1:0]   net_rf_waddr;
    logic [`CORE_DATA_W-1:0]  net_rf_wdata;
    logic                     start;
    logic [`CORE_IMEM_AW-1:0] start_pc;
    logic                     done;

    // Pipeline registers between stages
    logic                     f_valid;
    core_pkg::instr_u         f_instr;
    logic [`CORE_IMEM_AW-1:0] f_pc;
    logic                     d_valid;
    core_pkg::instr_u         d_instr;
    logic [`CORE_IMEM_AW-1:0] d_pc;
    logic [`CORE_DATA_W-1:0]  d_rs_val;
    logic [`CORE_DATA_W-1:0]  d_rd_val;
    logic                     d_writes_rf;
    logic                     x_valid;
    logic                     x_we;
    logic [`CORE_RF_AW-1:0]   x_waddr;
    logic [`CORE_DATA_W-1:0]  x_wdata;
    logic                     x_done;
    logic                     redirect;
    logic [`CORE_IMEM_AW-1:0] redirect_pc;

    net_ctrl u_net_ctrl (
        .clk(clk), .n_reset(n_reset),
        .pkt_valid_i(pkt_valid_i), .pkt_id_i(pkt_id_i), .pkt_op_i(pkt_op_i),
        .pkt_addr_i(pkt_addr_i), .pkt_data_i(pkt_data_i), .done_i(done),
        .imem_we_o(imem_we), .imem_waddr_o(imem_waddr), .imem_wdata_o(imem_wdata),
        .net_rf_we_o(net_rf_we), .net_rf_waddr_o(net_rf_waddr),
        .net_rf_wdata_o(net_rf_wdata), .start_o(start), .start_pc_o(start_pc),
        .running_o(running_o), .exception_o(exception_o)
    );

    fetch_unit u_fetch (
        .clk(clk), .n_reset(n_reset), .running_i(running_o),
        .start_i(start), .start_pc_i(start_pc),
        .redirect_i(redirect), .redirect_pc_i(redirect_pc),
        .imem_we_i(imem_we), .imem_waddr_i(imem_waddr), .imem_wdata_i(imem_wdata),
        .f_valid_o(f_valid), .f_instr_o(f_instr), .f_pc_o(f_pc)
    );

    // Register write port doubles as the trace
    decode_stage u_decode (
        .clk(clk), .n_reset(n_reset),
        .f_valid_i(f_valid), .f_instr_i(f_instr), .f_pc_i(f_pc), .flush_i(redirect),
        .rf_we_i(trace_we_o), .rf_waddr_i(trace_addr_o), .rf_wdata_i(trace_data_o),
        .d_valid_o(d_valid), .d_instr_o(d_instr), .d_pc_o(d_pc),
        .d_rs_val_o(d_rs_val), .d_rd_val_o(d_rd_val), .d_writes_rf_o(d_writes_rf)
    );

    execute_stage u_execute (
        .clk(clk), .n_reset(n_reset),
        .d_valid_i(d_valid), .d_instr_i(d_instr), .d_pc_i(d_pc),
        .d_rs_val_i(d_rs_val), .d_rd_val_i(d_rd_val), .d_writes_rf_i(d_writes_rf),
        .fwd_we_i(trace_we_o), .fwd_addr_i(trace_addr_o), .fwd_data_i(trace_data_o),
        .redirect_o(redirect), .redirect_pc_o(redirect_pc),
        .x_valid_o(x_valid), .x_we_o(x_we), .x_waddr_o(x_waddr),
        .x_wdata_o(x_wdata), .x_done_o(x_done)
    );

    result_stage u_result (
        .clk(clk), .n_reset(n_reset),
        .x_valid_i(x_valid), .x_we_i(x_we), .x_waddr_i(x_waddr),
        .x_wdata_i(x_wdata), .x_done_i(x_done),
        .net_rf_we_i(net_rf_we), .net_rf_waddr_i(net_rf_waddr),
        .net_rf_wdata_i(net_rf_wdata),
        .rf_we_o(trace_we_o), .rf_waddr_o(trace_addr_o), .rf_wdata_o(trace_data_o),
        .done_o(done)
    );

endmodule

// ==== dv/net_core_properties.sv ====
`timescale 1ns/100ps
`include "core_cfg.svh"

module net_core_properties (
    input logic                    clk,
    input logic                    n_reset,
    input logic                    running_i,
    input logic                    exception_i,
    input logic                    trace_we_i,
    input logic [`CORE_RF_AW-1:0]  trace_addr_i
);

    // Count of failed assertions
    int failures = 0;

    // Exception is sticky until the next reset
    exception_sticky: assert property (@(posedge clk) disable iff (!n_reset)
        !$fell(exception_i))
    else
    begin
        $error("exception_o fell without a reset");
        failures++;
    end

    // Register 0 is never written
    no_r0_write: assert property (@(posedge clk) disable iff (!n_reset)
        !(trace_we_i && (trace_addr_i == '0)))
    else
    begin
        $error("register write to r0 on the trace port");
        failures++;
    end

    // Core comes out of reset idle and clean
    reset_idle: assert property (@(posedge clk) $rose(n_reset) |-> !running_i && !exception_i)
    else
    begin
        $error("core not idle when reset released");
        failures++;
    end

endmodule

bind net_core net_core_properties props_i (
    .clk(clk), .n_reset(n_reset), .running_i(running_o), .exception_i(exception_o),
    .trace_we_i(trace_we_o), .trace_addr_i(trace_addr_o)
);

// ==== dv/net_core_checker.sv ====
`timescale 1ns/100ps
`include "core_cfg.svh"

module net_core_checker (
    input logic                     clk,
    input logic                     n_reset,
    input logic                     trace_we_i,
    input logic [`CORE_RF_AW-1:0]   trace_addr_i,
    input logic [`CORE_DATA_W-1:0]  trace_data_i
);

    // Expected register writes, oldest first
    logic [`CORE_RF_AW-1:0]  exp_addr_q[$];
    logic [`CORE_DATA_W-1:0] exp_data_q[$];
    int                      errors = 0;

    task automatic push_expected(input logic [`CORE_RF_AW-1:0] addr,
                                 input logic [`CORE_DATA_W-1:0] data);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
    endtask

    function automatic int pending();
        return exp_addr_q.size();
    endfunction

    // Trace is stable at the rising edge, inputs move on the falling one
    always @(posedge clk)
    begin
        logic [`CORE_RF_AW-1:0]  ea;
        logic [`CORE_DATA_W-1:0] ed;
        if (n_reset && trace_we_i)
        begin
            if (exp_addr_q.size() == 0)
            begin
                $display("ERROR at %0t: register write r%0d = %h was not expected",
                         $time, trace_addr_i, trace_data_i);
                errors++;
            end
            else
            begin
                ea = exp_addr_q.pop_front();
                ed = exp_data_q.pop_front();
                if (trace_addr_i !== ea)
                begin
                    $display("MISMATCH at %0t: trace_addr_o expected %0d got %0d",
                             $time, ea, trace_addr_i);
                    errors++;
                end
                if (trace_data_i !== ed)
                begin
                    $display("MISMATCH at %0t: trace_data_o expected %h got %h",
                             $time, ed, trace_data_i);
                    errors++;
                end
            end
        end
    end

endmodule

// ==== dv/net_core_tb.sv ====
`timescale 1ns/100ps
`include "core_cfg.svh"

module net_core_tb;

    localparam int KIND_PKT  = 0;
    localparam int KIND_WAIT = 1;
    localparam int MAX_ROWS  = 64;

    logic                      clk;
    logic                      n_reset;
    logic                      pkt_valid_i;
    logic [`CORE_NET_ID_W-1:0] pkt_id_i;
    core_pkg::net_op_e         pkt_op_i;
    logic [`CORE_IMEM_AW-1:0]  pkt_addr_i;
    logic [`CORE_DATA_W-1:0]   pkt_data_i;
    logic                      running_o;
    logic                      exception_o;
    logic                      trace_we_o;
    logic [`CORE_RF_AW-1:0]    trace_addr_o;
    logic [`CORE_DATA_W-1:0]   trace_data_o;

    // Stimulus table, one packet or wait marker per row
    int                        row_kind [MAX_ROWS];
    logic [`CORE_NET_ID_W-1:0] row_id [MAX_ROWS];
    core_pkg::net_op_e         row_op [MAX_ROWS];
    logic [`CORE_IMEM_AW-1:0]  row_addr [MAX_ROWS];
    logic [`CORE_DATA_W-1:0]   row_data [MAX_ROWS];
    logic                      row_nogap [MAX_ROWS];
    logic                      row_exp_we [MAX_ROWS];
    logic [`CORE_RF_AW-1:0]    row_exp_addr [MAX_ROWS];
    logic [`CORE_DATA_W-1:0]   row_exp_data [MAX_ROWS];
    int                        n_rows = 0;
    int                        tb_errors = 0;
    int                        cycles = 0;
    int                        limit = 0;

    net_core dut_i (.*);

    net_core_checker chk_i (
        .clk(clk), .n_reset(n_reset), .trace_we_i(trace_we_o),
        .trace_addr_i(trace_addr_o), .trace_data_i(trace_data_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Instruction word: opcode, rd, then rs or signed immediate
    function automatic logic [`CORE_DATA_W-1:0] encode(input core_pkg::opcode_e op,
                                                       input int rd, input int low);
        logic [`CORE_INSTR_W-1:0] w;
        w = {op, rd[`CORE_RF_AW-1:0], low[`CORE_RF_AW-1:0]};
        return {{(`CORE_DATA_W-`CORE_INSTR_W){1'b0}}, w};
    endfunction

    task automatic add_row(input int kind, input int id, input core_pkg::net_op_e op,
                           input int addr, input logic [`CORE_DATA_W-1:0] data,
                           input logic nogap, input logic exp_we, input int exp_addr,
                           input logic [`CORE_DATA_W-1:0] exp_data);
        row_kind[n_rows]     = kind;
        row_id[n_rows]       = id[`CORE_NET_ID_W-1:0];
        row_op[n_rows]       = op;
        row_addr[n_rows]     = addr[`CORE_IMEM_AW-1:0];
        row_data[n_rows]     = data;
        row_nogap[n_rows]    = nogap;
        row_exp_we[n_rows]   = exp_we;
        row_exp_addr[n_rows] = exp_addr[`CORE_RF_AW-1:0];
        row_exp_data[n_rows] = exp_data;
        n_rows++;
    endtask

    task automatic load_reg(input int id, input int r, input int val, input logic seen);
        add_row(KIND_PKT, id, core_pkg::NET_REG, r, val, 1'b0, seen, r, val);
    endtask

    // Expected write is the commit of this instruction, in program order
    task automatic load_instr(input int pc, input logic [`CORE_DATA_W-1:0] word,
                              input logic we, input int rd, input int val);
        add_row(KIND_PKT, 1, core_pkg::NET_INSTR, pc, word, 1'b0, we, rd, val);
    endtask

    task automatic build_table();
        //////////////////////////////
        // Network register writes
        //////////////////////////////
        load_reg(1, 1, 5, 1'b1);
        load_reg(1, 2, 3, 1'b1);
        // Foreign ID and r0 must stay off the trace
        load_reg(2, 3, 77, 1'b0);
        load_reg(1, 0, 99, 1'b0);
        load_reg(1, 4, 0, 1'b1);
        load_reg(1, 9, 20, 1'b1);
        // Dependent chain, forwarding from result and through the RF
        load_instr(0, encode(core_pkg::OP_ADD, 1, 2), 1'b1, 1, 8);
        load_instr(1, encode(core_pkg::OP_SUB, 1, 2), 1'b1, 1, 5);
        load_instr(2, encode(core_pkg::OP_AND, 1, 2), 1'b1, 1, 1);
        load_instr(3, encode(core_pkg::OP_OR, 2, 1), 1'b1, 2, 3);
        load_instr(4, encode(core_pkg::OP_MOV, 6, 1), 1'b1, 6, 1);
        load_instr(5, encode(core_pkg::OP_ADDI, 6, -3), 1'b1, 6, 32'hFFFF_FFFE);
        // BEQZ taken to 9, slots 7 and 8 are flushed
        load_instr(6, encode(core_pkg::OP_BEQZ, 4, 3), 1'b0, 0, 0);
        load_instr(7, encode(core_pkg::OP_ADDI, 7, 1), 1'b0, 0, 0);
        load_instr(8, encode(core_pkg::OP_ADDI, 7, 1), 1'b0, 0, 0);
        // BNEQZ not taken, then taken to 13
        load_instr(9, encode(core_pkg::OP_BNEQZ, 4, 5), 1'b0, 0, 0);
        load_instr(10, encode(core_pkg::OP_BNEQZ, 1, 3), 1'b0, 0, 0);
        load_instr(11, encode(core_pkg::OP_ADDI, 8, 1), 1'b0, 0, 0);
        load_instr(12, encode(core_pkg::OP_ADDI, 8, 1), 1'b0, 0, 0);
        // JALR links 14 and jumps to r9
        load_instr(13, encode(core_pkg::OP_JALR, 10, 9), 1'b1, 10, 14);
        load_instr(14, encode(core_pkg::OP_ADDI, 11, 1), 1'b0, 0, 0);
        load_instr(15, encode(core_pkg::OP_ADDI, 11, 1), 1'b0, 0, 0);
        load_instr(20, encode(core_pkg::OP_ADDI, 10, -1), 1'b1, 10, 13);
        load_instr(21, encode(core_pkg::OP_DONE, 0, 0), 1'b0, 0, 0);
        // Shadow of DONE never commits
        load_instr(22, encode(core_pkg::OP_ADDI, 12, 1), 1'b0, 0, 0);
        load_instr(23, encode(core_pkg::OP_ADDI, 12, 1), 1'b0, 0, 0);
        add_row(KIND_PKT, 1, core_pkg::NET_PC, 0, 0, 1'b0, 1'b0, 0, 0);
        // Wait marker carries the exception state expected once idle
        add_row(KIND_WAIT, 0, core_pkg::NET_NONE, 0, 0, 1'b1, 1'b0, 0, 0);
        //////////////////////////////
        // Second run, PC write while running
        //////////////////////////////
        load_instr(30, encode(core_pkg::OP_MOV, 13, 1), 1'b1, 13, 1);
        load_instr(31, encode(core_pkg::OP_ADD, 13, 13), 1'b1, 13, 2);
        // BEQZ not taken on the forwarded r13
        load_instr(32, encode(core_pkg::OP_BEQZ, 13, 3), 1'b0, 0, 0);
        load_instr(33, encode(core_pkg::OP_NOP, 0, 0), 1'b0, 0, 0);
        load_instr(34, encode(core_pkg::OP_DONE, 0, 0), 1'b0, 0, 0);
        // Branch target, also in the shadow of DONE
        load_instr(35, encode(core_pkg::OP_ADDI, 14, 1), 1'b0, 0, 0);
        add_row(KIND_PKT, 1, core_pkg::NET_PC, 30, 0, 1'b0, 1'b0, 0, 0);
        add_row(KIND_PKT, 1, core_pkg::NET_PC, 0, 0, 1'b1, 1'b0, 0, 0);
        add_row(KIND_WAIT, 0, core_pkg::NET_NONE, 0, 0, 1'b1, 1'b1, 0, 0);
    endtask

    // Run limit scales with the table length
    initial
    begin
        while ((limit == 0) || (cycles <= limit))
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the core never went idle", cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    initial
    begin
        int seed;
        int gap;
        seed        = $urandom(37);
        n_reset     = 1'b0;
        pkt_valid_i = 1'b0;
        pkt_id_i    = '0;
        pkt_op_i    = core_pkg::NET_NONE;
        pkt_addr_i  = '0;
        pkt_data_i  = '0;
        build_table();
        limit = n_rows * 40;
        repeat (8) @(posedge clk);
        @(negedge clk);
        n_reset = 1'b1;
        // Idle and quiet until the first start packet
        repeat (3)
        begin
            @(negedge clk);
            if (running_o || exception_o || trace_we_o)
            begin
                $display("ERROR at %0t: core not idle after reset", $time);
                tb_errors++;
            end
        end
        for (int i = 0; i < n_rows; i++)
        begin
            if ((row_kind[i] == KIND_PKT) && !row_nogap[i])
            begin
                pkt_valid_i = 1'b0;
                gap = $urandom % 3;
                repeat (gap) @(negedge clk);
            end
            if (row_kind[i] == KIND_WAIT)
            begin
                pkt_valid_i = 1'b0;
                while (running_o)
                    @(negedge clk);
                // Only a PC write while running may have raised it
                if (exception_o !== row_exp_we[i])
                begin
                    $display("MISMATCH at %0t: exception_o expected %0b got %0b",
                             $time, row_exp_we[i], exception_o);
                    tb_errors++;
                end
            end
            else
            begin
                pkt_valid_i = 1'b1;
                pkt_id_i    = row_id[i];
                pkt_op_i    = row_op[i];
                pkt_addr_i  = row_addr[i];
                pkt_data_i  = row_data[i];
                if (row_exp_we[i])
                    chk_i.push_expected(row_exp_addr[i], row_exp_data[i]);
                @(negedge clk);
            end
        end
        pkt_valid_i = 1'b0;
        repeat (10) @(negedge clk);
        if (!exception_o)
        begin
            $display("ERROR at %0t: PC write while running did not raise the exception", $time);
            tb_errors++;
        end
        if (chk_i.pending() != 0)
        begin
            $display("ERROR: %0d expected register writes never appeared", chk_i.pending());
            tb_errors++;
        end
        $display("Errors: checker %0d, testbench %0d, assertions %0d",
                 chk_i.errors, tb_errors, dut_i.props_i.failures);
        if ((chk_i.errors == 0) && (tb_errors == 0) && (dut_i.props_i.failures == 0))
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+src
src/core_pkg.sv
src/net_ctrl.sv
src/fetch_unit.sv
src/decode_stage.sv
src/execute_stage.sv
src/result_stage.sv
src/net_core.sv
dv/net_core_properties.sv
dv/net_core_checker.sv
dv/net_core_tb.sv
